/* verilog/jtag_pkg.sv */
package jtag_pkg;

	// tap controller states, ieee 1149.1 diagram
	typedef enum logic [3:0] {
		st_reset      = 4'h0,
		st_idle       = 4'h1,
		st_select_dr  = 4'h2,
		st_capture_dr = 4'h3,
		st_shift_dr   = 4'h4,
		st_exit1_dr   = 4'h5,
		st_pause_dr   = 4'h6,
		st_exit2_dr   = 4'h7,
		st_update_dr  = 4'h8,
		st_select_ir  = 4'h9,
		st_capture_ir = 4'ha,
		st_shift_ir   = 4'hb,
		st_exit1_ir   = 4'hc,
		st_pause_ir   = 4'hd,
		st_exit2_ir   = 4'he,
		st_update_ir  = 4'hf
	} tap_state_t;

	typedef logic [3:0] ir_t;

	// instruction codes
	localparam ir_t ir_idcode  = 4'h1;
	localparam ir_t ir_regfile = 4'h8;
	localparam ir_t ir_bypass  = 4'hf;

	// device id, lsb set as the standard requires
	localparam logic [31:0] idcode_val = 32'h1a7c_50e3;

	// longest data register, the regfile command
	localparam int dr_width = 48;
	typedef logic [dr_width-1:0] dr_t;

endpackage

/* verilog/regfile_pkg.sv */
package regfile_pkg;

	typedef logic [13:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;

	typedef enum logic {
		tc_domain = 1'b0,
		sc_domain = 1'b1
	} domain_t;

	typedef enum logic {
		read  = 1'b0,
		write = 1'b1
	} reg_op_t;

	// also the regfile command layout, op in the msb, data in the low word
	typedef struct packed {
		reg_op_t   op;
		domain_t   domain;
		reg_addr_t addr;
		reg_data_t data;
	} reg_req_t;

	// status and readback, captured into the low dr bits
	typedef struct packed {
		logic      done;
		logic      err;
		reg_data_t data;
	} reg_rsp_t;

	// bank sizes in words, and access wait states
	localparam int tc_depth = 16;
	localparam int sc_depth = 8;
	localparam int tc_wait  = 0;
	localparam int sc_wait  = 2;

endpackage

/* verilog/jtag_tap.sv */
`timescale 1ns/1ps

module jtag_tap
	import jtag_pkg::*, regfile_pkg::*;
(
	input  logic     ifc,
	input  logic     reset,
	input  logic     tck,
	input  logic     tms,
	input  logic     tdi,
	input  logic     trst_n,
	input  reg_rsp_t rsp,
	output logic     tdo,
	output logic     dr_update,
	output dr_t      dr_value
);

	typedef struct packed {
		logic tck;
		logic tms;
		logic tdi;
		logic trst_n;
	} pins_t;

	pins_t      pin_meta;
	pins_t      pin_sync;
	logic       tck_last;
	logic       tck_rise;
	logic       tck_fall;
	logic       tap_reset;
	tap_state_t state;
	tap_state_t state_next;
	ir_t        ir;
	ir_t        ir_sr;
	dr_t        dr;
	dr_t        dr_shifted;
	int         dr_len;

	// two flop sync on all pins, plus tck history for edges
	always_ff @(posedge ifc) begin
		if (reset) begin
			pin_meta <= '0;
			pin_sync <= '0;
			tck_last <= 1'b0;
		end else begin
			pin_meta <= '{tck: tck, tms: tms, tdi: tdi, trst_n: trst_n};
			pin_sync <= pin_meta;
			tck_last <= pin_sync.tck;
		end
	end

	assign tck_rise = pin_sync.tck && !tck_last;
	assign tck_fall = !pin_sync.tck && tck_last;
	// trst_n acts like a reset, only slower
	assign tap_reset = reset || !pin_sync.trst_n;

	always_comb begin
		case (state)
			st_reset:      state_next = pin_sync.tms ? st_reset : st_idle;
			st_idle:       state_next = pin_sync.tms ? st_select_dr : st_idle;
			st_select_dr:  state_next = pin_sync.tms ? st_select_ir : st_capture_dr;
			st_capture_dr: state_next = pin_sync.tms ? st_exit1_dr : st_shift_dr;
			st_shift_dr:   state_next = pin_sync.tms ? st_exit1_dr : st_shift_dr;
			st_exit1_dr:   state_next = pin_sync.tms ? st_update_dr : st_pause_dr;
			st_pause_dr:   state_next = pin_sync.tms ? st_exit2_dr : st_pause_dr;
			st_exit2_dr:   state_next = pin_sync.tms ? st_update_dr : st_shift_dr;
			st_update_dr:  state_next = pin_sync.tms ? st_select_dr : st_idle;
			st_select_ir:  state_next = pin_sync.tms ? st_reset : st_capture_ir;
			st_capture_ir: state_next = pin_sync.tms ? st_exit1_ir : st_shift_ir;
			st_shift_ir:   state_next = pin_sync.tms ? st_exit1_ir : st_shift_ir;
			st_exit1_ir:   state_next = pin_sync.tms ? st_update_ir : st_pause_ir;
			st_pause_ir:   state_next = pin_sync.tms ? st_exit2_ir : st_pause_ir;
			st_exit2_ir:   state_next = pin_sync.tms ? st_update_ir : st_shift_ir;
			default:       state_next = pin_sync.tms ? st_select_dr : st_idle;
		endcase
	end

	// five tms ones land in st_reset through the state table
	always_ff @(posedge ifc) begin
		if (tap_reset)
			state <= st_reset;
		else if (tck_rise)
			state <= state_next;
	end

	// idcode is the default instruction
	always_ff @(posedge ifc) begin
		if (tap_reset || state == st_reset)
			ir <= ir_idcode;
		else if (tck_rise && state_next == st_update_ir)
			ir <= ir_sr;
	end

	always_ff @(posedge ifc) begin
		if (tck_rise && state == st_capture_ir)
			ir_sr <= 4'b0001;
		else if (tck_rise && state == st_shift_ir)
			ir_sr <= {pin_sync.tdi, ir_sr[3:1]};
	end

	// selected dr length, unknown codes behave as bypass
	always_comb begin
		case (ir)
			ir_idcode:  dr_len = 32;
			ir_regfile: dr_len = dr_width;
			default:    dr_len = 1;
		endcase
	end

	// lsb first, tdi enters at the top of the selected length
	always_comb begin
		dr_shifted = dr >> 1;
		dr_shifted[dr_len-1] = pin_sync.tdi;
	end

	always_ff @(posedge ifc) begin
		if (tck_rise && state == st_capture_dr) begin
			case (ir)
				ir_idcode:  dr <= dr_t'(idcode_val);
				ir_regfile: dr <= dr_t'(rsp);
				default:    dr <= '0;
			endcase
		end else if (tck_rise && state == st_shift_dr) begin
			dr <= dr_shifted;
		end
	end

	assign dr_value = dr;

	// one ifc pulse on entry to update-dr, regfile only
	always_ff @(posedge ifc) begin
		if (tap_reset)
			dr_update <= 1'b0;
		else
			dr_update <= tck_rise && state_next == st_update_dr && ir == ir_regfile;
	end

	// tdo moves on the falling tck edge
	always_ff @(posedge ifc) begin
		if (tap_reset)
			tdo <= 1'b0;
		else if (tck_fall) begin
			if (state == st_shift_dr)
				tdo <= dr[0];
			else if (state == st_shift_ir)
				tdo <= ir_sr[0];
			else
				tdo <= 1'b0;
		end
	end

endmodule

/* verilog/jtag_cmd_decode.sv */
`timescale 1ns/1ps

module jtag_cmd_decode
	import jtag_pkg::*, regfile_pkg::*;
(
	input  logic     ifc,
	input  logic     reset,
	input  logic     dr_update,
	input  dr_t      dr_value,
	output logic     req_valid,
	output reg_req_t req,
	output logic     range_err
);

	reg_req_t cmd;
	logic     in_range;

	// command layout is the request struct itself
	assign cmd = dr_value;

	// bound by the depth of the addressed bank
	always_comb begin
		if (cmd.domain == sc_domain)
			in_range = cmd.addr < reg_addr_t'(sc_depth);
		else
			in_range = cmd.addr < reg_addr_t'(tc_depth);
	end

	// single cycle strobes, mutually exclusive
	always_ff @(posedge ifc) begin
		if (reset) begin
			req_valid <= 1'b0;
			range_err <= 1'b0;
		end else begin
			req_valid <= dr_update && in_range;
			range_err <= dr_update && !in_range;
		end
	end

	// request fields held until the next update
	always_ff @(posedge ifc) begin
		if (dr_update)
			req <= cmd;
	end

endmodule

/* verilog/apb_reg_master.sv */
`timescale 1ns/1ps

module apb_reg_master
	import regfile_pkg::*;
(
	input  logic      ifc,
	input  logic      reset,
	input  logic      req_valid,
	input  reg_req_t  req,
	input  logic      range_err,
	input  reg_data_t prdata_tc,
	input  reg_data_t prdata_sc,
	input  logic      pready_tc,
	input  logic      pready_sc,
	input  logic      pslverr_tc,
	input  logic      pslverr_sc,
	output reg_addr_t paddr,
	output logic      pwrite,
	output reg_data_t pwdata,
	output logic      penable,
	output logic      psel_tc,
	output logic      psel_sc,
	output reg_rsp_t  rsp
);

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} apb_state_t;

	apb_state_t state;
	domain_t    domain;
	logic       sel_ready;
	logic       sel_err;
	reg_data_t  sel_rdata;

	// slave return path picked by the latched domain
	assign sel_ready = (domain == sc_domain) ? pready_sc : pready_tc;
	assign sel_err   = (domain == sc_domain) ? pslverr_sc : pslverr_tc;
	assign sel_rdata = (domain == sc_domain) ? prdata_sc : prdata_tc;

	assign psel_tc = state != st_idle && domain == tc_domain;
	assign psel_sc = state != st_idle && domain == sc_domain;
	assign penable = state == st_access;

	always_ff @(posedge ifc) begin
		if (reset) begin
			state <= st_idle;
			rsp   <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (req_valid) begin
						state    <= st_setup;
						rsp.done <= 1'b0;
						rsp.err  <= 1'b0;
					end else if (range_err) begin
						// rejected command completes at once with error
						rsp.done <= 1'b1;
						rsp.err  <= 1'b1;
					end
				end
				st_setup: state <= st_access;
				default: begin
					if (sel_ready) begin
						state    <= st_idle;
						rsp.done <= 1'b1;
						if (!pwrite)
							rsp.data <= sel_rdata;
						if (sel_err)
							rsp.err <= 1'b1;
					end
				end
			endcase
			// overrun, a command arrived mid transfer and was dropped
			if (state != st_idle && (req_valid || range_err))
				rsp.err <= 1'b1;
		end
	end

	// transfer fields latched on accept
	always_ff @(posedge ifc) begin
		if (state == st_idle && req_valid) begin
			paddr  <= req.addr;
			pwrite <= req.op == write;
			pwdata <= req.data;
			domain <= req.domain;
		end
	end

endmodule

/* verilog/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank
	import regfile_pkg::*;
#(
	parameter int depth       = 16,
	parameter int wait_states = 0
) (
	input  logic      ifc,
	input  logic      reset,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  reg_addr_t paddr,
	input  reg_data_t pwdata,
	output reg_data_t prdata,
	output logic      pready,
	output logic      pslverr
);

	localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

	reg_data_t        mem [depth];
	logic [cnt_w-1:0] wait_cnt;
	logic [idx_w-1:0] idx;
	logic             access;
	logic             in_range;

	assign access   = psel && penable;
	assign in_range = paddr < reg_addr_t'(depth);
	assign idx      = paddr[idx_w-1:0];

	// ready once the access phase has waited long enough
	assign pready  = access && (wait_cnt == cnt_w'(wait_states));
	// flags a stray address, decode upstream keeps this low
	assign pslverr = pready && !in_range;
	assign prdata  = in_range ? mem[idx] : '0;

	// counts access cycles, cleared between transfers
	always_ff @(posedge ifc) begin
		if (reset)
			wait_cnt <= '0;
		else if (access && !pready)
			wait_cnt <= wait_cnt + 1'b1;
		else
			wait_cnt <= '0;
	end

	always_ff @(posedge ifc) begin
		if (reset) begin
			for (int i = 0; i < depth; i++)
				mem[i] <= '0;
		end else if (pready && pwrite && in_range) begin
			mem[idx] <= pwdata;
		end
	end

endmodule

/* verilog/jtag_regfile_top.sv */
`timescale 1ns/1ps

module jtag_regfile_top
	import jtag_pkg::*, regfile_pkg::*;
(
	input  logic ifc,
	input  logic reset,
	input  logic tck,
	input  logic tms,
	input  logic tdi,
	input  logic trst_n,
	output logic tdo
);

	logic      dr_update;
	dr_t       dr_value;
	logic      req_valid;
	reg_req_t  req;
	logic      range_err;
	reg_rsp_t  rsp;
	reg_addr_t paddr;
	logic      pwrite;
	reg_data_t pwdata;
	logic      penable;
	logic      psel_tc;
	logic      psel_sc;
	reg_data_t prdata_tc;
	reg_data_t prdata_sc;
	logic      pready_tc;
	logic      pready_sc;
	logic      pslverr_tc;
	logic      pslverr_sc;

	jtag_tap tap_i (
		.ifc       (ifc),
		.reset     (reset),
		.tck       (tck),
		.tms       (tms),
		.tdi       (tdi),
		.trst_n    (trst_n),
		.rsp       (rsp),
		.tdo       (tdo),
		.dr_update (dr_update),
		.dr_value  (dr_value)
	);

	jtag_cmd_decode decode_i (
		.ifc       (ifc),
		.reset     (reset),
		.dr_update (dr_update),
		.dr_value  (dr_value),
		.req_valid (req_valid),
		.req       (req),
		.range_err (range_err)
	);

	apb_reg_master master_i (
		.ifc        (ifc),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.range_err  (range_err),
		.prdata_tc  (prdata_tc),
		.prdata_sc  (prdata_sc),
		.pready_tc  (pready_tc),
		.pready_sc  (pready_sc),
		.pslverr_tc (pslverr_tc),
		.pslverr_sc (pslverr_sc),
		.paddr      (paddr),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.penable    (penable),
		.psel_tc    (psel_tc),
		.psel_sc    (psel_sc),
		.rsp        (rsp)
	);

	// test control bank, no wait states
	reg_bank #(
		.depth       (tc_depth),
		.wait_states (tc_wait)
	) tc_bank_i (
		.ifc     (ifc),
		.reset   (reset),
		.psel    (psel_tc),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata_tc),
		.pready  (pready_tc),
		.pslverr (pslverr_tc)
	);

	// slow control bank
	reg_bank #(
		.depth       (sc_depth),
		.wait_states (sc_wait)
	) sc_bank_i (
		.ifc     (ifc),
		.reset   (reset),
		.psel    (psel_sc),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata_sc),
		.pready  (pready_sc),
		.pslverr (pslverr_sc)
	);

endmodule

/* test/jtag_regfile_chk.sv */
`timescale 1ns/1ps

module jtag_regfile_chk
	import regfile_pkg::*;
(
	input logic      ifc,
	input logic      reset,
	input logic      psel_tc,
	input logic      psel_sc,
	input logic      penable,
	input logic      pready_tc,
	input logic      pready_sc,
	input logic      pwrite,
	input reg_addr_t paddr
);

	logic psel;
	logic pready;
	// failed assertions so far
	int   fail_count = 0;

	assign psel = psel_tc || psel_sc;
	// ready of the selected slave only
	assign pready = (psel_tc && pready_tc) || (psel_sc && pready_sc);

	// access phase always inside a selected transfer
	penable_needs_psel: assert property (@(posedge ifc) disable iff (reset)
		penable |-> psel)
		else begin
			fail_count++;
			$error("penable high while no slave is selected");
		end

	// one bank per transfer
	single_psel: assert property (@(posedge ifc) disable iff (reset)
		!(psel_tc && psel_sc))
		else begin
			fail_count++;
			$error("both bank selects high in the same cycle");
		end

	// address and direction held until the slave completes
	fields_stable: assert property (@(posedge ifc) disable iff (reset)
		(psel && !pready) |=> ($stable(paddr) && $stable(pwrite)))
		else begin
			fail_count++;
			$error("paddr or pwrite changed before pready");
		end

endmodule

bind apb_reg_master jtag_regfile_chk chk_i (
	.ifc       (ifc),
	.reset     (reset),
	.psel_tc   (psel_tc),
	.psel_sc   (psel_sc),
	.penable   (penable),
	.pready_tc (pready_tc),
	.pready_sc (pready_sc),
	.pwrite    (pwrite),
	.paddr     (paddr)
);

/* test/jtag_regfile_tb.sv */
`timescale 1ns/1ps

module jtag_regfile_tb
	import jtag_pkg::*, regfile_pkg::*;
();

	logic ifc;
	logic reset;
	logic tck;
	logic tms;
	logic tdi;
	logic trst_n;
	logic tdo;

	int seed;
	int checks;
	int value_errors;
	int timeouts;

	// expected bank contents per domain
	reg_data_t tc_model [int];
	reg_data_t sc_model [int];

	jtag_regfile_top dut_i (
		.ifc    (ifc),
		.reset  (reset),
		.tck    (tck),
		.tms    (tms),
		.tdi    (tdi),
		.trst_n (trst_n),
		.tdo    (tdo)
	);

	always #4 ifc = ~ifc;

	// one tck period of four ifc cycles per phase
	// tdo sampled just before the rise once the fall has settled
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(negedge ifc);
		tck = 1'b0;
		tms = tms_v;
		tdi = tdi_v;
		repeat (4) @(negedge ifc);
		tdo_v = tdo;
		tck = 1'b1;
		repeat (3) @(negedge ifc);
	endtask

	task automatic idle_cycles(input int n);
		logic unused;
		repeat (n) tck_cycle(1'b0, 1'b0, unused);
	endtask

	// five tms ones and then park in run-test/idle
	task automatic tap_reset();
		logic unused;
		repeat (5) tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	// idle to idle through the ir column with the lsb first
	task automatic shift_ir(input ir_t code);
		logic unused;
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		for (int i = 0; i < 4; i++)
			tck_cycle(i == 3, code[i], unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	// idle to idle through the dr column leaving shift on the last bit
	task automatic shift_dr(input dr_t din, input int len, output dr_t dout);
		logic bit_out;
		dout = '0;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	function automatic int depth_of(input domain_t dom);
		return (dom == sc_domain) ? sc_depth : tc_depth;
	endfunction

	function automatic reg_data_t model_value(input domain_t dom, input reg_addr_t addr);
		return (dom == sc_domain) ? sc_model[int'(addr)] : tc_model[int'(addr)];
	endfunction

	// issue the command and scan it again to capture its response
	// the repeated scan reissues the same command
	task automatic reg_access(input reg_req_t cmd, output reg_rsp_t rsp);
		dr_t  captured;
		logic seen_done;
		seen_done = 1'b0;
		rsp = '0;
		shift_dr(dr_t'(cmd), dr_width, captured);
		for (int tries = 0; tries < 4 && !seen_done; tries++) begin
			// room for the apb transfer before the next capture
			idle_cycles(16);
			shift_dr(dr_t'(cmd), dr_width, captured);
			rsp = reg_rsp_t'(captured[33:0]);
			seen_done = rsp.done;
		end
		idle_cycles(16);
		assert (seen_done) else begin
			timeouts++;
			$display("register access to domain %0d address %h never reported done",
				cmd.domain, cmd.addr);
		end
	endtask

	task automatic run_checked(input reg_req_t cmd);
		reg_rsp_t  rsp;
		logic      exp_err;
		reg_data_t exp_data;
		exp_err = int'(cmd.addr) >= depth_of(cmd.domain);
		reg_access(cmd, rsp);
		checks++;
		assert (rsp.err === exp_err) else begin
			value_errors++;
			$display("FAIL rsp.err: got %h expected %h (domain %0d address %h)",
				rsp.err, exp_err, cmd.domain, cmd.addr);
		end
		if (!exp_err && cmd.op == read) begin
			exp_data = model_value(cmd.domain, cmd.addr);
			checks++;
			assert (rsp.data === exp_data) else begin
				value_errors++;
				$display("FAIL rsp.data: got %h expected %h (domain %0d address %h)",
					rsp.data, exp_data, cmd.domain, cmd.addr);
			end
		end
		// only accepted writes reach a bank
		if (!exp_err && cmd.op == write) begin
			if (cmd.domain == sc_domain)
				sc_model[int'(cmd.addr)] = cmd.data;
			else
				tc_model[int'(cmd.addr)] = cmd.data;
		end
	endtask

	task automatic reg_write(input domain_t dom, input reg_addr_t addr, input reg_data_t data);
		reg_req_t cmd;
		cmd.op     = write;
		cmd.domain = dom;
		cmd.addr   = addr;
		cmd.data   = data;
		run_checked(cmd);
	endtask

	task automatic reg_read(input domain_t dom, input reg_addr_t addr);
		reg_req_t cmd;
		cmd.op     = read;
		cmd.domain = dom;
		cmd.addr   = addr;
		cmd.data   = '0;
		run_checked(cmd);
	endtask

	// 32 bit dr scan returns idcode whatever goes in
	task automatic check_idcode(input string when_txt);
		dr_t captured;
		shift_dr('0, 32, captured);
		checks++;
		assert (captured[31:0] === idcode_val) else begin
			value_errors++;
			$display("FAIL tdo idcode %s: got %h expected %h",
				when_txt, captured[31:0], idcode_val);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] exp_bypass;
		dr_t         din;
		dr_t         dout;
		domain_t     dom;
		reg_addr_t   addr;
		int          assert_fails;
		seed = 32'h8648;
		checks = 0;
		value_errors = 0;
		timeouts = 0;
		ifc = 1'b0;
		reset = 1'b1;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		for (int a = 0; a < tc_depth; a++)
			tc_model[a] = '0;
		for (int a = 0; a < sc_depth; a++)
			sc_model[a] = '0;
		repeat (16) @(negedge ifc);
		reset = 1'b0;

		// idcode straight out of reset without an ir scan
		idle_cycles(1);
		check_idcode("after reset");

		// trst_n pulse drops bypass back to idcode
		shift_ir(ir_bypass);
		@(negedge ifc);
		trst_n = 1'b0;
		repeat (8) @(negedge ifc);
		trst_n = 1'b1;
		idle_cycles(1);
		check_idcode("after trst_n");

		// tms ones drop regfile back to idcode
		shift_ir(ir_regfile);
		tap_reset();
		check_idcode("after tms reset");

		// bypass returns tdi one shift late behind the captured zero
		shift_ir(ir_bypass);
		din = dr_t'($random(seed));
		shift_dr(din, 32, dout);
		exp_bypass = {din[30:0], 1'b0};
		checks++;
		assert (dout[31:0] === exp_bypass) else begin
			value_errors++;
			$display("FAIL tdo bypass: got %h expected %h", dout[31:0], exp_bypass);
		end

		shift_ir(ir_regfile);
		// same address in both banks keeps separate values
		reg_write(tc_domain, 14'd3, reg_data_t'($random(seed)));
		reg_write(sc_domain, 14'd3, reg_data_t'($random(seed)));
		reg_read(tc_domain, 14'd3);
		reg_read(sc_domain, 14'd3);
		// first word past the end of sc would alias word 0
		reg_write(sc_domain, reg_addr_t'(sc_depth), reg_data_t'($random(seed)));

		// random mix with about one address in eight out of range
		for (int n = 0; n < 24; n++) begin
			r = $random(seed);
			dom = domain_t'(r[0]);
			if (r[4:2] == 3'd0)
				addr = reg_addr_t'(depth_of(dom) + int'(r[10:5]));
			else
				addr = reg_addr_t'(int'(r[15:5]) % depth_of(dom));
			if (r[1])
				reg_write(dom, addr, reg_data_t'($random(seed)));
			else
				reg_read(dom, addr);
		end

		// every word of both banks against the model
		for (int a = 0; a < tc_depth; a++)
			reg_read(tc_domain, reg_addr_t'(a));
		for (int a = 0; a < sc_depth; a++)
			reg_read(sc_domain, reg_addr_t'(a));

		assert_fails = dut_i.master_i.chk_i.fail_count;
		$display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
			checks, value_errors, timeouts, assert_fails);
		if (value_errors == 0 && timeouts == 0 && assert_fails == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* list.f */
verilog/jtag_pkg.sv
verilog/regfile_pkg.sv
verilog/jtag_tap.sv
verilog/jtag_cmd_decode.sv
verilog/apb_reg_master.sv
verilog/reg_bank.sv
verilog/jtag_regfile_top.sv
test/jtag_regfile_chk.sv
test/jtag_regfile_tb.sv

/* Makefile */
TOP = jtag_regfile_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "run ended without a result"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
